/* rtl/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // ========================================
    // Widths and constants
    // ========================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int DMEM_WORDS = 64;        // Data memory depth in words.

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                         // Used for the JAL link value.
    } alu_op_e;

    // ========================================
    // Stage-to-stage payloads
    // ========================================
    typedef struct packed {
        word_t    pc;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    src1_r;                  // Register-file values read at issue.
        word_t    src2_r;
        alu_op_e  alu_op;
        logic     src2_is_imm;
        logic     gpr_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
    } uop_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     gpr_we;
        logic     is_load;
        logic     is_store;
        word_t    result;                  // ALU value, or the address for memory ops.
        word_t    store_data;
    } mem_req_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu (
    input  wire exec_pkg::alu_op_e op,
    input  wire exec_pkg::word_t   a,
    input  wire exec_pkg::word_t   b,
    output exec_pkg::word_t        result,
    output logic                   equal
);
    import exec_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign equal = (a == b);               // Branch compare on the raw operands.

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`default_nettype none

module regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire exec_pkg::reg_idx_t rs1_addr,
    input  wire exec_pkg::reg_idx_t rs2_addr,
    output exec_pkg::word_t         rs1_data,
    output exec_pkg::word_t         rs2_data,
    input  wire                     we,
    input  wire exec_pkg::retire_t  wb
);
    import exec_pkg::*;

    word_t regs [1:31];                    // x0 has no storage.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle writes are visible on the read ports.
    assign rs1_data = (rs1_addr == '0)            ? '0 :
                      (we && wb.rd == rs1_addr)   ? wb.data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)            ? '0 :
                      (we && wb.rd == rs2_addr)   ? wb.data : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/issue_stage.sv */
`default_nettype none

module issue_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     inst_valid,
    input  wire exec_pkg::word_t    inst_word,
    input  wire exec_pkg::word_t    inst_pc,
    output logic                    inst_ready,
    input  wire                     redirect_valid,
    input  wire exec_pkg::word_t    redirect_pc,
    output exec_pkg::reg_idx_t      rs1_addr,
    output exec_pkg::reg_idx_t      rs2_addr,
    input  wire exec_pkg::word_t    rs1_data,
    input  wire exec_pkg::word_t    rs2_data,
    output logic                    uop_valid,
    output exec_pkg::uop_t          uop,
    input  wire                     exu_ready
);
    import exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    uop_t        dec;
    logic        supported;
    logic        pending;                  // Waiting for the redirect target word.
    logic        drop;
    logic        take;
    logic [2:0]  funct3;

    assign funct3   = inst_word[14:12];
    assign rs1_addr = inst_word[19:15];
    assign rs2_addr = inst_word[24:20];

    always_comb begin
        dec         = '0;
        dec.pc      = inst_pc;
        dec.rs1     = inst_word[19:15];
        dec.rs2     = inst_word[24:20];
        dec.rd      = inst_word[11:7];
        dec.src1_r  = rs1_data;
        dec.src2_r  = rs2_data;
        dec.alu_op  = ALU_ADD;
        supported   = 1'b1;
        case (inst_word[6:0])
            OPC_OP: begin
                dec.gpr_we = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = inst_word[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: supported  = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_LOAD: begin
                dec.imm         = {{20{inst_word[31]}}, inst_word[31:20]};
                dec.rs2         = '0;
                dec.src2_is_imm = 1'b1;
                dec.gpr_we      = 1'b1;
                dec.is_load     = (inst_word[6:0] == OPC_LOAD);
                supported       = dec.is_load ? (funct3 == 3'b010) : (funct3 == 3'b000);
            end
            OPC_STORE: begin
                dec.imm = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
                dec.rd          = '0;
                dec.src2_is_imm = 1'b1;
                dec.is_store    = 1'b1;
                supported       = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                dec.imm = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                           inst_word[30:25], inst_word[11:8], 1'b0};
                dec.rd        = '0;
                dec.alu_op    = ALU_SUB;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                supported     = (funct3[2:1] == 2'b00);
            end
            OPC_JAL: begin
                dec.imm = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                           inst_word[20], inst_word[30:21], 1'b0};
                dec.rs1    = '0;
                dec.rs2    = '0;
                dec.alu_op = ALU_PASS_B;
                dec.gpr_we = 1'b1;
                dec.is_jal = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    assign drop       = redirect_valid || (pending && inst_pc != redirect_pc);
    assign inst_ready = drop || !uop_valid || exu_ready;
    assign take       = inst_valid && inst_ready && !drop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending   <= 1'b0;
            uop_valid <= 1'b0;
        end else if (redirect_valid) begin
            pending   <= 1'b1;             // The held micro-op is on the wrong path.
            uop_valid <= 1'b0;
        end else begin
            if (take) begin
                pending <= 1'b0;
            end
            if (take) begin
                uop_valid <= 1'b1;
            end else if (exu_ready) begin
                uop_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            uop <= dec;
        end
    end

    a_supported_op: assert property (@(posedge clk) disable iff (rst) take |-> supported)
        else $error("Unsupported instruction %h accepted at pc %h.", inst_word, inst_pc);

endmodule

`default_nettype wire

/* rtl/exu.sv */
`default_nettype none

module exu #(
    parameter int BYPASS_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     uop_valid,
    input  wire exec_pkg::uop_t     uop,
    output logic                    exu_ready,
    output logic                    mem_valid,
    output exec_pkg::mem_req_t      mem_req,
    input  wire                     lsu_ready,
    input  wire                     load_done,
    input  wire exec_pkg::word_t    load_data,
    output logic                    redirect_valid,
    output exec_pkg::word_t         redirect_pc
);
    import exec_pkg::*;

    // ========================================
    // Forwarding table with the youngest entry first
    // ========================================
    reg_idx_t byp_rd    [BYPASS_DEPTH];
    word_t    byp_data  [BYPASS_DEPTH];
    logic     byp_valid [BYPASS_DEPTH];
    logic     byp_pend  [BYPASS_DEPTH];
    word_t    fdata     [BYPASS_DEPTH];   // Table contents with this cycle's load filled in.
    logic     fpend     [BYPASS_DEPTH];
    logic     fill_done;

    word_t src1, src2, op_b, alu_result, target;
    logic  wait1, wait2, alu_equal, taken, accept, shift;

    always_comb begin
        fill_done = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            fdata[i] = byp_data[i];
            fpend[i] = byp_pend[i];
            if (load_done && !fill_done && byp_valid[i] && byp_pend[i]) begin
                fdata[i]  = load_data;    // Oldest pending load gets the return data.
                fpend[i]  = 1'b0;
                fill_done = 1'b1;
            end
        end
    end

    always_comb begin
        src1  = uop.src1_r;
        src2  = uop.src2_r;
        wait1 = 1'b0;
        wait2 = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (byp_valid[i] && byp_rd[i] == uop.rs1 && uop.rs1 != '0) begin
                src1  = fdata[i];
                wait1 = fpend[i];
            end
            if (byp_valid[i] && byp_rd[i] == uop.rs2 && uop.rs2 != '0) begin
                src2  = fdata[i];
                wait2 = fpend[i];
            end
        end
    end

    assign exu_ready = (!mem_valid || lsu_ready) && !wait1 && !wait2;
    assign accept    = uop_valid && exu_ready && !redirect_valid;
    assign shift     = accept && uop.gpr_we;
    assign op_b      = uop.is_jal ? uop.pc + 32'd4 : (uop.src2_is_imm ? uop.imm : src2);

    alu alu_i (.op(uop.alu_op), .a(src1), .b(op_b), .result(alu_result), .equal(alu_equal));
    alu target_alu_i (.op(ALU_ADD), .a(uop.pc), .b(uop.imm), .result(target), .equal());

    assign taken = uop.is_jal || (uop.is_branch && (alu_equal != uop.branch_ne));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                byp_valid[i] <= 1'b0;
                byp_pend[i]  <= 1'b0;
            end
        end else if (shift) begin
            byp_valid[0] <= 1'b1;
            byp_pend[0]  <= uop.is_load;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                byp_valid[i] <= byp_valid[i-1];
                byp_pend[i]  <= fpend[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                byp_pend[i] <= fpend[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            byp_rd[0]   <= uop.rd;
            byp_data[0] <= alu_result;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                byp_rd[i]   <= byp_rd[i-1];
                byp_data[i] <= fdata[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                byp_data[i] <= fdata[i];
            end
        end
    end

    // ========================================
    // Output register and redirect
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (accept) begin
                mem_valid <= 1'b1;
            end else if (lsu_ready) begin
                mem_valid <= 1'b0;
            end
            redirect_valid <= accept && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_req <= '{rd: uop.rd, gpr_we: uop.gpr_we, is_load: uop.is_load,
                         is_store: uop.is_store, result: alu_result, store_data: src2};
        end
        if (accept && taken) begin
            redirect_pc <= target;
        end
    end

    a_fill_found: assert property (@(posedge clk) disable iff (rst)
        load_done |-> fill_done)
        else $error("Load data returned with no pending entry in the forwarding table.");

endmodule

`default_nettype wire

/* rtl/lsu.sv */
`default_nettype none

module lsu (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       mem_valid,
    input  wire exec_pkg::mem_req_t   mem_req,
    output logic                      lsu_ready,
    output logic                      load_done,
    output exec_pkg::word_t           load_data,
    output logic                      retire_valid,
    output exec_pkg::retire_t         retire
);
    import exec_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    typedef enum logic {IDLE, LOAD_WAIT} state_e;

    state_e   state;
    word_t    dmem [DMEM_WORDS];
    reg_idx_t ld_rd;
    logic [AW-1:0] ld_idx;
    logic     accept;

    assign lsu_ready = (state == IDLE);
    assign accept    = mem_valid && lsu_ready;
    assign load_data = retire.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            retire_valid <= 1'b0;
            load_done    <= 1'b0;
        end else begin
            retire_valid <= (accept && !mem_req.is_load) || (state == LOAD_WAIT);
            load_done    <= (state == LOAD_WAIT);
            if (state == LOAD_WAIT) begin
                state <= IDLE;
            end else if (accept && mem_req.is_load) begin
                state <= LOAD_WAIT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD_WAIT) begin
            retire <= '{rd: ld_rd, data: dmem[ld_idx]};
        end else if (accept) begin
            ld_rd  <= mem_req.rd;
            ld_idx <= mem_req.result[AW+1:2];
            retire <= '{rd: mem_req.gpr_we ? mem_req.rd : '0, data: mem_req.result};
            if (mem_req.is_store) begin
                dmem[mem_req.result[AW+1:2]] <= mem_req.store_data;
            end
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        accept && (mem_req.is_load || mem_req.is_store) |-> mem_req.result[31:AW+2] == '0)
        else $error("Data address %h outside memory.", mem_req.result);

endmodule

`default_nettype wire

/* rtl/exec_core.sv */
`default_nettype none

module exec_core #(
    parameter int BYPASS_DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     inst_valid,
    input  wire exec_pkg::word_t    inst_word,
    input  wire exec_pkg::word_t    inst_pc,
    output logic                    inst_ready,
    output logic                    redirect_valid,
    output exec_pkg::word_t         redirect_pc,
    output logic                    retire_valid,
    output exec_pkg::retire_t       retire
);
    import exec_pkg::*;

    reg_idx_t rs1_addr, rs2_addr;
    word_t    rs1_data, rs2_data;
    logic     uop_valid, exu_ready;
    uop_t     uop;
    logic     mem_valid, lsu_ready, load_done;
    mem_req_t mem_req;
    word_t    load_data;

    issue_stage issue_stage_i (
        .clk, .rst, .inst_valid, .inst_word, .inst_pc, .inst_ready,
        .redirect_valid, .redirect_pc, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .uop_valid, .uop, .exu_ready
    );

    exu #(.BYPASS_DEPTH(BYPASS_DEPTH)) exu_i (
        .clk, .rst, .uop_valid, .uop, .exu_ready, .mem_valid, .mem_req,
        .lsu_ready, .load_done, .load_data, .redirect_valid, .redirect_pc
    );

    lsu lsu_i (
        .clk, .rst, .mem_valid, .mem_req, .lsu_ready, .load_done, .load_data,
        .retire_valid, .retire
    );

    regfile regfile_i (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we(retire_valid), .wb(retire)     // Commit on the retire edge.
    );

endmodule

`default_nettype wire

/* sim/exec_core_tb.sv */
`default_nettype none

module exec_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 20;
    localparam int PROG_LEN     = 26;
    localparam int EXP_LEN      = 18;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 40 * EXP_LEN) * CLK_PERIOD;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    // Register writes in program order without the x0 writes.
    localparam retire_t EXPECTED [EXP_LEN] = '{
        '{5'd1,  32'h0000_0005}, '{5'd2,  32'hffff_fffd}, '{5'd3,  32'h0000_0002},
        '{5'd4,  32'hffff_fff8}, '{5'd5,  32'h0000_0005}, '{5'd6,  32'hffff_fffd},
        '{5'd7,  32'hffff_fff8}, '{5'd8,  32'h0000_0001}, '{5'd9,  32'h0000_0000},
        '{5'd10, 32'h0000_0007}, '{5'd10, 32'h0000_000e}, '{5'd10, 32'h0000_0009},
        '{5'd11, 32'h0000_0009}, '{5'd12, 32'h0000_000e}, '{5'd15, 32'h0000_004c},
        '{5'd16, 32'h0000_0050}, '{5'd17, 32'h0000_0050}, '{5'd18, 32'h0000_0042}
    };
    localparam word_t REDIRECTS [2] = '{32'h0000_0048, 32'h0000_0054};

    logic    clk = 1'b0;
    logic    rst;
    logic    inst_valid;
    word_t   inst_word;
    word_t   inst_pc;
    logic    inst_ready;
    logic    redirect_valid;
    word_t   redirect_pc;
    logic    retire_valid;
    retire_t retire;

    word_t   prog [PROG_LEN];
    word_t   fetch_pc = '0;
    integer  seed = 32'h06ec_ab06;
    int      errors = 0;
    int      n_retired = 0;
    int      n_redirects = 0;

    exec_core #(.BYPASS_DEPTH(4)) exec_core_i (
        .clk, .rst, .inst_valid, .inst_word, .inst_pc, .inst_ready,
        .redirect_valid, .redirect_pc, .retire_valid, .retire
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // RV32I instruction encoders
    // ========================================
    function automatic word_t r_word(input logic [6:0] f7, input logic [4:0] rd,
                                     input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_word(input logic [6:0] opc, input logic [4:0] rd,
                                     input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t j_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ========================================
    // Fetch model
    // ========================================
    always @(posedge clk) begin : fetch
        word_t next_pc;
        logic  free;
        next_pc = fetch_pc;
        free    = !inst_valid || inst_ready;
        if (redirect_valid) begin
            next_pc = redirect_pc;                  // Restart at the branch target.
            free    = 1'b1;
        end else if (inst_valid && inst_ready) begin
            next_pc = fetch_pc + 32'd4;
        end
        if (rst) begin
            fetch_pc   <= '0;
            inst_valid <= 1'b0;
        end else if (free) begin
            fetch_pc <= next_pc;
            if (($random(seed) & 3) != 0 && next_pc[31:2] < PROG_LEN) begin
                inst_valid <= 1'b1;
                inst_word  <= prog[next_pc[31:2]];
                inst_pc    <= next_pc;
            end else begin
                inst_valid <= 1'b0;                 // Random bubble or end of program.
            end
        end
    end

    // ========================================
    // Monitors
    // ========================================
    always @(posedge clk) begin
        if (retire_valid && retire.rd != '0) begin
            if (n_retired >= EXP_LEN) begin
                $display("Unexpected retirement of x%0d at %0t.", retire.rd, $time);
                errors++;
            end else begin
                if (retire.rd != EXPECTED[n_retired].rd) begin
                    $display("MISMATCH at %0t: retire.rd got %0d expected %0d", $time,
                             retire.rd, EXPECTED[n_retired].rd);
                    errors++;
                end
                if (retire.data != EXPECTED[n_retired].data) begin
                    $display("MISMATCH at %0t: retire.data got %h expected %h", $time,
                             retire.data, EXPECTED[n_retired].data);
                    errors++;
                end
            end
            n_retired++;
        end
    end

    always @(posedge clk) begin
        if (redirect_valid) begin
            if (n_redirects >= 2) begin
                $display("Unexpected redirect to %h at %0t.", redirect_pc, $time);
                errors++;
            end else if (redirect_pc != REDIRECTS[n_redirects]) begin
                $display("MISMATCH at %0t: redirect_pc got %h expected %h", $time,
                         redirect_pc, REDIRECTS[n_redirects]);
                errors++;
            end
            n_redirects++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout with %0d of %0d retirements, errors %0d", n_retired, EXP_LEN,
                 errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        prog[0]  = i_word(OPC_OP_IMM, 5'd1, 3'b000, 5'd0, 12'd5);
        prog[1]  = i_word(OPC_OP_IMM, 5'd2, 3'b000, 5'd0, -12'sd3);
        prog[2]  = r_word(7'b0000000, 5'd3, 3'b000, 5'd1, 5'd2);    // ADD
        prog[3]  = r_word(7'b0100000, 5'd4, 3'b000, 5'd2, 5'd1);    // SUB
        prog[4]  = r_word(7'b0000000, 5'd5, 3'b111, 5'd1, 5'd2);    // AND
        prog[5]  = r_word(7'b0000000, 5'd6, 3'b110, 5'd1, 5'd2);    // OR
        prog[6]  = r_word(7'b0000000, 5'd7, 3'b100, 5'd1, 5'd2);    // XOR
        prog[7]  = r_word(7'b0000000, 5'd8, 3'b010, 5'd2, 5'd1);    // SLT with -3 < 5.
        prog[8]  = r_word(7'b0000000, 5'd9, 3'b010, 5'd1, 5'd2);
        prog[9]  = i_word(OPC_OP_IMM, 5'd10, 3'b000, 5'd10, 12'd7);
        prog[10] = r_word(7'b0000000, 5'd10, 3'b000, 5'd10, 5'd10);
        prog[11] = r_word(7'b0100000, 5'd10, 3'b000, 5'd10, 5'd1);
        prog[12] = s_word(5'd10, 5'd0, 12'd8);
        prog[13] = i_word(OPC_LOAD, 5'd11, 3'b010, 5'd0, 12'd8);
        prog[14] = r_word(7'b0000000, 5'd12, 3'b000, 5'd11, 5'd1);  // Load-use stall.
        prog[15] = b_word(3'b000, 5'd1, 5'd1, 13'd12);              // BEQ taken to 0x48.
        prog[16] = i_word(OPC_OP_IMM, 5'd13, 3'b000, 5'd0, 12'd99);
        prog[17] = i_word(OPC_OP_IMM, 5'd14, 3'b000, 5'd0, 12'd99);
        prog[18] = j_word(5'd15, 21'd12);                           // JAL to 0x54.
        prog[19] = i_word(OPC_OP_IMM, 5'd13, 3'b000, 5'd0, 12'd1);
        prog[20] = i_word(OPC_OP_IMM, 5'd14, 3'b000, 5'd0, 12'd1);
        prog[21] = b_word(3'b001, 5'd1, 5'd1, 13'd8);               // BNE not taken.
        prog[22] = i_word(OPC_OP_IMM, 5'd16, 3'b000, 5'd15, 12'd4);
        prog[23] = s_word(5'd16, 5'd0, 12'd12);
        prog[24] = i_word(OPC_LOAD, 5'd17, 3'b010, 5'd0, 12'd12);
        prog[25] = r_word(7'b0100000, 5'd18, 3'b000, 5'd17, 5'd12);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait (n_retired >= EXP_LEN);
        repeat (DRAIN_CYCLES) @(posedge clk);       // Catch late or extra retirements.
        if (n_retired != EXP_LEN) begin
            $display("Retired %0d instructions where %0d were expected.", n_retired, EXP_LEN);
            errors++;
        end
        if (n_redirects != 2) begin
            $display("Saw %0d redirects where 2 were expected.", n_redirects);
            errors++;
        end
        $display("Retirements %0d/%0d, redirects %0d/2, errors %0d", n_retired, EXP_LEN,
                 n_redirects, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/exec_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/issue_stage.sv
rtl/exu.sv
rtl/lsu.sv
rtl/exec_core.sv
sim/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - rtl/exec_pkg.sv
  - rtl/alu.sv
  - rtl/regfile.sv
  - rtl/issue_stage.sv
  - rtl/exu.sv
  - rtl/lsu.sv
  - rtl/exec_core.sv
  - target: test
    files:
      - sim/exec_core_tb.sv
